// ==== all.f ====
common/fetch_pkg.sv
fetch_queue/fetch_queue.sv
hdl/fetch_pc_gen.sv
hdl/fetch_resp_align.sv
hdl/fetch_top.sv
testbench/imem_model.sv
testbench/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f all.f --top-module tb_fetch_top -o sim_fetch
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_fetch)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

// ==== testbench/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*;;

    localparam logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] MTVEC_VAL   = 64'h0000_0012_0000_0100;
    localparam logic [XLEN-1:0] MEPC_VAL    = 64'h0000_0012_0000_2404;
    localparam logic [31:0]     FILL_KEY    = 32'h5a3c_96e1;
    localparam int              TEST_CYCLES = 500;
    localparam int              TIMEOUT     = TEST_CYCLES * 4;
    localparam int              READY_ALWAYS = 0;
    localparam int              READY_RANDOM = 1;
    localparam int              READY_STALL  = 2;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            imem_req_valid;
    imem_req_t       imem_req;
    logic            imem_req_ready;
    logic            imem_rsp_valid;
    imem_rsp_t       imem_rsp;
    logic            instr_valid;
    fetch_instr_t    instr;
    logic            instr_ready;
    logic            intr;
    logic            jump;
    logic [XLEN-1:0] jump_pc;
    logic            trap_enter;
    logic            trap_ret;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    integer          seed = 49;
    int              ready_mode = READY_ALWAYS;
    string           test_name = "reset";
    logic [XLEN-1:0] exp_pc = RESET_PC;
    logic            exp_epoch = 1'b0;
    logic            epoch_known = 1'b0;
    redirect_cause_e last_cause = CAUSE_NONE;
    int              delivered = 0;
    int              req_fires = 0;
    int              check_errors = 0;
    int              stim_errors = 0;
    int              cycles = 0;
    logic            timed_out = 1'b0;

    fetch_top #(
        .RESET_PC        (RESET_PC),
        .QUEUE_DEPTH     (4),
        .MAX_OUTSTANDING (4)
    ) DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .imem_req_valid_o (imem_req_valid),
        .imem_req_o       (imem_req),
        .imem_req_ready_i (imem_req_ready),
        .imem_rsp_valid_i (imem_rsp_valid),
        .imem_rsp_i       (imem_rsp),
        .instr_valid_o    (instr_valid),
        .instr_o          (instr),
        .instr_ready_i    (instr_ready),
        .intr_i           (intr),
        .jump_i           (jump),
        .jump_pc_i        (jump_pc),
        .trap_enter_i     (trap_enter),
        .trap_ret_i       (trap_ret),
        .mtvec_i          (mtvec),
        .mepc_i           (mepc)
    );

    imem_model #(
        .SEED     (49),
        .FILL_KEY (FILL_KEY)
    ) u_imem (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (imem_req_valid),
        .req_i       (imem_req),
        .req_ready_o (imem_req_ready),
        .rsp_valid_o (imem_rsp_valid),
        .rsp_o       (imem_rsp)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] expected_word(input logic [XLEN-1:0] pc);
        return pc[31:0] ^ pc[63:32] ^ FILL_KEY;
    endfunction

    // interrupt first, then jump, trap entry, trap return
    function automatic redirect_cause_e expected_cause(input logic i, input logic j,
                                                       input logic te, input logic tr);
        if (i) return CAUSE_INTR;
        if (j) return CAUSE_JUMP;
        if (te) return CAUSE_TRAP_ENTER;
        if (tr) return CAUSE_TRAP_RET;
        return CAUSE_NONE;
    endfunction

    function automatic logic [XLEN-1:0] expected_target(input redirect_cause_e c,
                                                        input logic [XLEN-1:0] jpc,
                                                        input logic [XLEN-1:0] pc);
        case (c)
            CAUSE_INTR, CAUSE_TRAP_ENTER: return mtvec;
            CAUSE_JUMP:                   return jpc;
            CAUSE_TRAP_RET:               return mepc;
            default:                      return pc + 64'd4;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] random_target();
        logic [31:0] r;
        r = $random(seed);
        return {32'h0000_0003, 16'h8000, r[15:2], 2'b00};
    endfunction

    function automatic logic pick_ready();
        logic [31:0] r;
        r = $random(seed);
        case (ready_mode)
            READY_ALWAYS: return 1'b1;
            READY_STALL:  return 1'b0;
            default:      return r[0];
        endcase
    endfunction

    // reference pc stream and comparison of every accepted pair
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc = RESET_PC;
            epoch_known = 1'b0;
        end else begin
            if (imem_req_valid && imem_req_ready) begin
                req_fires = req_fires + 1;
                // first request sets the epoch base, redirects toggle it
                if (!epoch_known) begin
                    exp_epoch = imem_req.epoch;
                    epoch_known = 1'b1;
                end else if (imem_req.epoch != exp_epoch) begin
                    $display("FAIL %s: request epoch expected %0b actual %0b",
                             test_name, exp_epoch, imem_req.epoch);
                    check_errors = check_errors + 1;
                end
            end
            if (intr || jump || trap_enter || trap_ret) begin
                // a request at the redirect edge still carries the old epoch
                exp_epoch = ~exp_epoch;
                last_cause = expected_cause(intr, jump, trap_enter, trap_ret);
                exp_pc = expected_target(last_cause, jump_pc, exp_pc);
            end else if (instr_valid && instr_ready) begin
                if (instr.pc != exp_pc) begin
                    $display("FAIL %s: pc after %s expected %h actual %h",
                             test_name, last_cause.name(), exp_pc, instr.pc);
                    check_errors = check_errors + 1;
                end
                if (instr.instr != expected_word(exp_pc)) begin
                    $display("FAIL %s: instr at pc %h expected %h actual %h",
                             test_name, exp_pc, expected_word(exp_pc), instr.instr);
                    check_errors = check_errors + 1;
                end
                // next pc in program order
                exp_pc = exp_pc + 64'd4;
                delivered = delivered + 1;
            end
        end
    end

    task automatic finish_run();
        int total;
        total = check_errors + stim_errors + (timed_out ? 1 : 0);
        $display("instructions checked %0d, value errors %0d, other errors %0d",
                 delivered, check_errors, stim_errors + (timed_out ? 1 : 0));
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout in %s, run did not finish within %0d cycles",
                     test_name, TIMEOUT);
            timed_out = 1'b1;
            finish_run();
        end
    end

    task automatic step();
        @(negedge clk);
        intr        = 1'b0;
        jump        = 1'b0;
        trap_enter  = 1'b0;
        trap_ret    = 1'b0;
        instr_ready = pick_ready();
    endtask

    // flags are intr, jump, trap_enter, trap_ret from msb down
    task automatic apply_redirect(input logic [3:0] flags);
        @(negedge clk);
        intr        = flags[3];
        jump        = flags[2];
        trap_enter  = flags[1];
        trap_ret    = flags[0];
        jump_pc     = random_target();
        instr_ready = 1'b0;
    endtask

    task automatic wait_deliveries(input int n);
        int goal;
        goal = delivered + n;
        while (delivered < goal) begin
            step();
        end
    endtask

    initial begin
        logic [31:0] r;
        int          fires_mark;
        rst_n       = 1'b0;
        intr        = 1'b0;
        jump        = 1'b0;
        jump_pc     = '0;
        trap_enter  = 1'b0;
        trap_ret    = 1'b0;
        mtvec       = MTVEC_VAL;
        mepc        = MEPC_VAL;
        instr_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "sequential";
        wait_deliveries(16);

        // jumps with responses still in flight, then back to back
        test_name = "jump";
        apply_redirect(4'b0100);
        wait_deliveries(4);
        apply_redirect(4'b0100);
        step();
        apply_redirect(4'b0100);
        wait_deliveries(4);
        apply_redirect(4'b0100);
        apply_redirect(4'b0100);
        wait_deliveries(4);

        test_name = "priority";
        for (int c = 1; c < 16; c++) begin
            apply_redirect(c[3:0]);
            wait_deliveries(3);
        end

        test_name = "random";
        ready_mode = READY_RANDOM;
        for (int i = 0; i < 150; i++) begin
            r = $random(seed);
            if (r[4:0] == 5'd0) begin
                apply_redirect((r[8:5] == 4'd0) ? 4'b0100 : r[8:5]);
            end else begin
                step();
            end
        end

        // queue fills, then request issue must stop
        test_name = "backpressure";
        ready_mode = READY_STALL;
        repeat (25) step();
        fires_mark = req_fires;
        repeat (15) step();
        if (req_fires != fires_mark) begin
            $display("%s: requests kept issuing while the fetch queue was full", test_name);
            stim_errors = stim_errors + 1;
        end
        if (!instr_valid) begin
            $display("%s: no instruction waiting after a long decode stall", test_name);
            stim_errors = stim_errors + 1;
        end
        ready_mode = READY_ALWAYS;
        wait_deliveries(12);

        repeat (4) step();
        finish_run();
    end

endmodule

// ==== testbench/imem_model.sv ====
`timescale 1ns/1ps

module imem_model import fetch_pkg::*; #(
    parameter int          SEED     = 49,
    parameter logic [31:0] FILL_KEY = 32'h5a3c_96e1
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid_i,
    input  imem_req_t req_i,
    output logic      req_ready_o,
    output logic      rsp_valid_o,
    output imem_rsp_t rsp_o
);

    integer          seed        = SEED;
    int unsigned     edge_cnt    = 0;
    int unsigned     last_due    = 0;
    logic            ready_r     = 1'b0;
    logic            rsp_valid_r = 1'b0;
    logic [XLEN-1:0] rsp_data_r  = '0;
    logic [XLEN-1:0] pend_data [$];
    int unsigned     pend_due [$];

    assign req_ready_o = ready_r;
    assign rsp_valid_o = rsp_valid_r;
    assign rsp_o.data  = rsp_data_r;

    // each 32-bit word is its byte address folded to 32 bits, xor a key
    function automatic logic [31:0] word_at(input logic [XLEN-1:0] addr);
        return addr[31:0] ^ addr[63:32] ^ FILL_KEY;
    endfunction

    // accepted requests get a due edge 1 to 4 cycles out, kept in order
    always @(posedge clk) begin
        int unsigned due;
        edge_cnt = edge_cnt + 1;
        if (!rst_n) begin
            pend_data.delete();
            pend_due.delete();
        end else if (req_valid_i && ready_r) begin
            due = edge_cnt + 1 + ($random(seed) & 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            pend_data.push_back({word_at(req_i.addr + 64'd4), word_at(req_i.addr)});
            pend_due.push_back(due);
        end
    end

    // ready stalls about one cycle in four
    always @(negedge clk) begin
        ready_r = (($random(seed) & 3) != 0);
        if (pend_due.size() != 0 && pend_due[0] <= edge_cnt + 1) begin
            rsp_valid_r = 1'b1;
            rsp_data_r  = pend_data.pop_front();
            void'(pend_due.pop_front());
        end else begin
            rsp_valid_r = 1'b0;
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC        = 64'h0000_0000_8000_0000,
    parameter int              QUEUE_DEPTH     = 4,
    parameter int              MAX_OUTSTANDING = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    // instruction memory request
    output logic            imem_req_valid_o,
    output imem_req_t       imem_req_o,
    input  logic            imem_req_ready_i,
    // instruction memory response
    input  logic            imem_rsp_valid_i,
    input  imem_rsp_t       imem_rsp_i,
    // decode side
    output logic            instr_valid_o,
    output fetch_instr_t    instr_o,
    input  logic            instr_ready_i,
    // redirects
    input  logic            intr_i,
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_pc_i,
    input  logic            trap_enter_i,
    input  logic            trap_ret_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i
);

    logic                             credit_ok;
    logic                             flush;
    logic [XLEN-1:0]                  req_pc;
    logic                             req_fire;
    logic                             push_valid;
    fetch_instr_t                     push_data;
    logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count;

    assign req_fire = imem_req_valid_o && imem_req_ready_i;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .intr_i       (intr_i),
        .jump_i       (jump_i),
        .jump_pc_i    (jump_pc_i),
        .trap_enter_i (trap_enter_i),
        .trap_ret_i   (trap_ret_i),
        .mtvec_i      (mtvec_i),
        .mepc_i       (mepc_i),
        .credit_ok_i  (credit_ok),
        .req_ready_i  (imem_req_ready_i),
        .req_valid_o  (imem_req_valid_o),
        .req_o        (imem_req_o),
        .req_pc_o     (req_pc),
        .flush_o      (flush)
    );

    // the request epoch is also the current epoch
    fetch_resp_align #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .QUEUE_DEPTH     (QUEUE_DEPTH)
    ) u_resp_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush),
        .req_fire_i    (req_fire),
        .req_pc_i      (req_pc),
        .req_epoch_i   (imem_req_o.epoch),
        .cur_epoch_i   (imem_req_o.epoch),
        .rsp_valid_i   (imem_rsp_valid_i),
        .rsp_i         (imem_rsp_i),
        .queue_count_i (queue_count),
        .push_valid_o  (push_valid),
        .push_o        (push_data),
        .credit_ok_o   (credit_ok)
    );

    fetch_queue #(
        .DEPTH (QUEUE_DEPTH),
        .T     (fetch_instr_t)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush),
        .push_valid_i (push_valid),
        .push_data_i  (push_data),
        .pop_ready_i  (instr_ready_i),
        .pop_valid_o  (instr_valid_o),
        .pop_data_o   (instr_o),
        .count_o      (queue_count)
    );

endmodule

// ==== hdl/fetch_resp_align.sv ====
`timescale 1ns/1ps

module fetch_resp_align import fetch_pkg::*; #(
    parameter int MAX_OUTSTANDING = 4,
    parameter int QUEUE_DEPTH     = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               flush_i,
    input  logic                               req_fire_i,
    input  logic [XLEN-1:0]                    req_pc_i,
    input  logic                               req_epoch_i,
    input  logic                               cur_epoch_i,
    input  logic                               rsp_valid_i,
    input  imem_rsp_t                          rsp_i,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   queue_count_i,
    output logic                               push_valid_o,
    output fetch_instr_t                       push_o,
    output logic                               credit_ok_o
);

    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam int SUM_W = $clog2(MAX_OUTSTANDING + QUEUE_DEPTH + 2);

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            epoch;
    } tag_t;

    tag_t                       tags_q [MAX_OUTSTANDING];
    logic [MAX_OUTSTANDING-1:0] live_q;
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [CNT_W-1:0]           tag_cnt_q;
    tag_t                       head;
    logic                       rsp_keep;
    logic [ILEN-1:0]            half;
    logic [SUM_W-1:0]           in_use;

    assign head = tags_q[rd_ptr_q];

    // epoch catches a single redirect
    // live bits also cover back-to-back redirects where the epoch wraps
    assign rsp_keep = rsp_valid_i && live_q[rd_ptr_q] && (head.epoch == cur_epoch_i) && !flush_i;
    assign half     = head.pc[2] ? rsp_i.data[63:32] : rsp_i.data[31:0];

    // tag fifo bookkeeping, every response pops one tag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            tag_cnt_q <= '0;
            live_q    <= '0;
        end else begin
            if (req_fire_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rsp_valid_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            tag_cnt_q <= tag_cnt_q + CNT_W'(req_fire_i) - CNT_W'(rsp_valid_i);
            // a request issued at the flush edge is already stale
            if (flush_i) begin
                live_q <= '0;
            end else if (req_fire_i) begin
                live_q[wr_ptr_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire_i) begin
            tags_q[wr_ptr_q] <= '{pc: req_pc_i, epoch: req_epoch_i};
        end
    end

    // one register stage before the queue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_valid_o <= 1'b0;
        end else begin
            push_valid_o <= rsp_keep;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_keep) begin
            push_o <= '{pc: head.pc, instr: half};
        end
    end

    // in flight, in the push stage and queued must all fit in the queue
    assign in_use = SUM_W'(tag_cnt_q) + SUM_W'(push_valid_o) + SUM_W'(queue_count_i);
    assign credit_ok_o = (tag_cnt_q < CNT_W'(MAX_OUTSTANDING)) && (in_use < SUM_W'(QUEUE_DEPTH));

    a_rsp_has_tag: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid_i |-> tag_cnt_q != '0
    ) else $error("response arrived with no request outstanding");

    a_tag_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_fire_i && !rsp_valid_i |-> tag_cnt_q < CNT_W'(MAX_OUTSTANDING)
    ) else $error("tag fifo overflow");

endmodule

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen import fetch_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            intr_i,
    input  logic            jump_i,
    input  logic [XLEN-1:0] jump_pc_i,
    input  logic            trap_enter_i,
    input  logic            trap_ret_i,
    input  logic [XLEN-1:0] mtvec_i,
    input  logic [XLEN-1:0] mepc_i,
    input  logic            credit_ok_i,
    input  logic            req_ready_i,
    output logic            req_valid_o,
    output imem_req_t       req_o,
    output logic [XLEN-1:0] req_pc_o,
    output logic            flush_o
);

    logic [XLEN-1:0] pc_q;
    logic            epoch_q;
    logic            run_q;
    logic            hold_q;
    logic [XLEN-1:0] target;
    redirect_cause_e cause;
    logic            req_fire;

    // fixed priority, interrupt wins over everything
    always_comb begin
        cause  = CAUSE_NONE;
        target = pc_q + XLEN'(4);
        if (intr_i) begin
            cause  = CAUSE_INTR;
            target = mtvec_i;
        end else if (jump_i) begin
            cause  = CAUSE_JUMP;
            target = jump_pc_i;
        end else if (trap_enter_i) begin
            cause  = CAUSE_TRAP_ENTER;
            target = mtvec_i;
        end else if (trap_ret_i) begin
            cause  = CAUSE_TRAP_RET;
            target = mepc_i;
        end
    end

    assign flush_o = (cause != CAUSE_NONE);

    // once raised, valid stays up until the handshake
    // credit taken at that point still covers the request
    assign req_valid_o = run_q && (credit_ok_i || hold_q);
    assign req_fire    = req_valid_o && req_ready_i;

    assign req_o.addr  = {pc_q[XLEN-1:3], 3'b000};
    assign req_o.epoch = epoch_q;
    assign req_pc_o    = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q    <= RESET_PC;
            epoch_q <= 1'b0;
            run_q   <= 1'b0;
            hold_q  <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            hold_q <= req_valid_o && !req_ready_i;
            if (flush_o) begin
                pc_q    <= target;
                epoch_q <= ~epoch_q;
            end else if (req_fire) begin
                pc_q <= target;
            end
        end
    end

    // a stalled request only changes when a redirect replaces it
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid_o && !req_ready_i && !flush_o |=> req_valid_o && $stable(req_o)
    ) else $error("fetch request changed while stalled without redirect");

endmodule

// ==== fetch_queue/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [31:0]
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush_i,
    input  logic                       push_valid_i,
    input  T                           push_data_i,
    input  logic                       pop_ready_i,
    output logic                       pop_valid_o,
    output T                           pop_data_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // push relies on the producer's credits, no ready towards it
    assign do_push = push_valid_i && !flush_i;
    assign do_pop  = pop_valid_o && pop_ready_i && !flush_i;

    assign pop_valid_o = (count_q != '0);
    assign pop_data_o  = mem_q[rd_ptr_q];
    assign count_o     = count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // flush drops everything including a push in the same cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push_valid_i |-> count_q < CNT_W'(DEPTH)
    ) else $error("push into full fetch queue");

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // address and data width
    localparam int XLEN = 64;
    // instruction width, no compressed support
    localparam int ILEN = 32;

    // request towards instruction memory
    // addr is always doubleword aligned
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            epoch;
    } imem_req_t;

    // response from instruction memory, one full doubleword
    typedef struct packed {
        logic [XLEN-1:0] data;
    } imem_rsp_t;

    // pair handed to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } fetch_instr_t;

    // source of the next pc, in priority order after none
    typedef enum logic [2:0] {
        CAUSE_NONE       = 3'd0,
        CAUSE_INTR       = 3'd1,
        CAUSE_JUMP       = 3'd2,
        CAUSE_TRAP_ENTER = 3'd3,
        CAUSE_TRAP_RET   = 3'd4
    } redirect_cause_e;

endpackage
